// File: project.f
source/rv32i_pkg.sv
source/ex_forward_mux.sv
source/ex_alu.sv
source/ex_branch_gen.sv
source/ex_control.sv
source/rv32i_ex.sv
sim/tb_clock_gen.sv
sim/tb_rv32i_ex.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file="sim.log"
build_dir="obj_dir"

if ! verilator --binary --timing --assert \
        --top-module tb_rv32i_ex \
        --Mdir "$build_dir" -o tb_sim \
        -f project.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$build_dir/tb_sim" > "$log_file" 2>&1; then
    cat "$log_file"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$log_file"

if grep -q "All tests passed!" "$log_file"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic Clk,
    output logic rst
);

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;    // 4 ns period
    end

    // Released 1 ns after the fourth edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge Clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: sim/tb_rv32i_ex.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_ex;

    import rv32i_pkg::*;

    logic         Clk;
    logic         rst;
    logic         in_valid;
    ex_ctrl_t     in_ctrl;
    ex_operands_t in_ops;
    fwd_sel_e     fwd_a;
    fwd_sel_e     fwd_b;
    word_t        mem_result;
    word_t        wb_result;
    ex_result_t   result;

    word_t        rng_state;
    int           fail_count;
    ex_result_t   model_q;      // Last expected output
    ex_result_t   exp_q[$];

    tb_clock_gen i_clock_gen (
        .Clk (Clk),
        .rst (rst)
    );

    rv32i_ex i_dut (
        .Clk        (Clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ctrl    (in_ctrl),
        .in_ops     (in_ops),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .mem_result (mem_result),
        .wb_result  (wb_result),
        .result     (result)
    );

    //////////////////////////////////////////////////
    // Random numbers and reference model
    //////////////////////////////////////////////////

    function automatic word_t next_rand();
        word_t x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        return next_rand() % n;
    endfunction

    function automatic word_t ref_forward(fwd_sel_e sel, word_t reg_val);
        if (sel == fwd_mem) return mem_result;
        if (sel == fwd_wb) return wb_result;
        return reg_val;
    endfunction

    function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
        logic [4:0] sh;
        word_t      r;
        sh = b[4:0];
        case (op)
            alu_add:  r = a + b;
            alu_sub:  r = a - b;
            alu_sll:  r = a << sh;
            alu_slt:  r = (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
            alu_sltu: r = word_t'(a < b);
            alu_xor:  r = a ^ b;
            alu_srl:  r = a >> sh;
            alu_sra: begin
                r = a >> sh;
                if (a[31]) r = r | ~({xlen{1'b1}} >> sh);    // Fill with sign
            end
            alu_or:   r = a | b;
            alu_and:  r = a & b;
            alu_eq:   r = word_t'(a == b);
            default:  r = '0;
        endcase
        return r;
    endfunction

    // Expected output for the inputs now on the DUT ports
    function automatic ex_result_t ref_result();
        word_t      rs1f;
        word_t      rs2f;
        word_t      a;
        word_t      b;
        word_t      alu;
        word_t      dest;
        logic       take;
        ex_result_t r;
        rs1f = ref_forward(fwd_a, in_ops.rs1);
        rs2f = ref_forward(fwd_b, in_ops.rs2);
        a = (in_ctrl.src_sel inside {src_ir, src_ii}) ? in_ops.imm1 : rs1f;
        b = (in_ctrl.src_sel inside {src_ri, src_ii}) ? in_ops.imm2 : rs2f;
        if (in_ctrl.jump) begin
            alu  = in_ops.imm1 + 32'd1;    // Word-addressed link
            take = 1'b1;
        end else begin
            alu  = ref_alu(in_ctrl.alu_op, a, b);
            take = (in_ctrl.br_op != br_none) && (alu[0] != in_ctrl.br_invert);
        end
        dest = (in_ctrl.br_op == br_reg_rel) ? rs1f + in_ops.imm2 : in_ops.pc + in_ops.imm2;
        r        = model_q;
        r.valid  = in_valid;
        r.pc_sel = in_valid && take;
        if (in_valid) begin
            r.alu_result  = alu;
            r.branch_dest = dest;
        end
        return r;
    endfunction

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic fail_run(string why);
        fail_count++;
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected)
            fail_run($sformatf("ERR %s: expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_result(string name, ex_result_t expected, ex_result_t actual);
        if (actual.valid !== expected.valid || actual.pc_sel !== expected.pc_sel)
            fail_run($sformatf("ERR %s valid,pc_sel: expected %b,%b actual %b,%b", name,
                expected.valid, expected.pc_sel, actual.valid, actual.pc_sel));
        if (expected.valid && (actual.alu_result !== expected.alu_result ||
                actual.branch_dest !== expected.branch_dest))
            fail_run($sformatf("ERR %s alu_result,branch_dest: expected %h,%h actual %h,%h",
                name, expected.alu_result, expected.branch_dest,
                actual.alu_result, actual.branch_dest));
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Drive happens now, the result is read one edge later
    task automatic step(string name);
        ex_result_t expected;
        exp_q.push_back(ref_result());
        model_q = exp_q[$];
        @(posedge Clk);
        #1;
        expected = exp_q.pop_front();
        check_result(name, expected, result);
    endtask

    task automatic random_operands();
        in_ops.pc   = next_rand();
        in_ops.rs1  = next_rand();
        in_ops.rs2  = next_rand();
        in_ops.imm1 = next_rand();
        in_ops.imm2 = next_rand();
        mem_result  = next_rand();
        wb_result   = mem_result ^ (next_rand() | 32'd1);    // Never equal to mem_result
        fwd_a       = fwd_sel_e'(2'(rand_below(3)));
        fwd_b       = fwd_sel_e'(2'(rand_below(3)));
    endtask

    task automatic random_ctrl();
        in_ctrl.alu_op    = alu_op_e'(4'(rand_below(11)));
        in_ctrl.src_sel   = src_sel_e'(2'(rand_below(4)));
        in_ctrl.br_invert = 1'(rand_below(2));
        in_ctrl.jump      = 1'(rand_below(2));
        case (rand_below(3))
            0: in_ctrl.br_op = br_none;
            1: in_ctrl.br_op = br_pc_rel;
            default: in_ctrl.br_op = br_reg_rel;
        endcase
    endtask

    task automatic wait_reset_done();
        ex_result_t zeros;
        int         cycles;
        zeros  = '0;
        cycles = 0;
        do begin
            @(negedge Clk);
            cycles++;
            if (rst) check_result("reset", zeros, result);
        end while (rst !== 1'b0 && cycles < 20);
        if (rst !== 1'b0) begin
            fail_run("Reset never ended within 20 clock cycles");
        end else begin
            @(posedge Clk);
            #1;
            check_result("reset_exit", zeros, result);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        word_t base;
        rng_state  = 32'd31157;
        fail_count = 0;
        model_q    = '0;
        in_valid   = 1'b0;
        in_ctrl    = '0;
        in_ops     = '0;
        fwd_a      = fwd_reg;
        fwd_b      = fwd_reg;
        mem_result = '0;
        wb_result  = '0;
        wait_reset_done();

        // Every code against every operand source
        for (int i = 0; i < 440; i++) begin
            random_operands();
            random_ctrl();
            in_ctrl.alu_op  = alu_op_e'(4'(i % 11));
            in_ctrl.src_sel = src_sel_e'(2'((i / 11) % 4));
            in_ctrl.br_op   = br_none;
            in_ctrl.jump    = 1'b0;
            fwd_a           = fwd_reg;
            fwd_b           = fwd_reg;
            in_valid        = 1'b1;
            step("alu");
        end

        for (int s = 0; s < 3; s++) begin
            random_operands();
            fwd_a    = fwd_sel_e'(2'(s));
            in_ctrl  = '{alu_op: alu_add, src_sel: src_rr, br_op: br_reg_rel,
                         br_invert: 1'b0, jump: 1'b0};
            in_valid = 1'b1;
            base     = (s == 0) ? in_ops.rs1 : (s == 1) ? mem_result : wb_result;
            step("fwd_directed");
            check_word("fwd_target", base + in_ops.imm2, result.branch_dest);
        end
        for (int i = 0; i < 300; i++) begin
            random_operands();
            random_ctrl();
            in_ctrl.jump = 1'b0;
            in_valid     = 1'b1;
            step("forward");
        end

        for (int i = 0; i < 400; i++) begin
            random_operands();
            random_ctrl();
            in_ctrl.jump  = 1'b0;
            in_ctrl.br_op = (i % 2 == 0) ? br_pc_rel : br_reg_rel;
            case (i % 3)
                0: in_ctrl.alu_op = alu_eq;
                1: in_ctrl.alu_op = alu_slt;
                default: in_ctrl.alu_op = alu_sltu;
            endcase
            if (rand_below(3) == 0) begin
                in_ctrl.src_sel = src_rr;    // Force an equal pair
                in_ops.rs2      = in_ops.rs1;
                fwd_b           = fwd_a;
            end
            in_valid = 1'b1;
            step("branch");
        end

        for (int i = 0; i < 200; i++) begin
            random_operands();
            random_ctrl();
            in_ctrl.jump = 1'b1;
            in_valid     = 1'b1;
            step("jump");
            check_word("jump_link", in_ops.imm1 + 32'd1, result.alu_result);
        end

        // Back-to-back with bubbles
        for (int i = 0; i < 2000; i++) begin
            random_operands();
            random_ctrl();
            in_valid = (rand_below(4) != 0);
            step("random");
            if (!in_valid) begin
                // Payload of the last live instruction stays put
                check_word("hold_alu_result", model_q.alu_result, result.alu_result);
                check_word("hold_branch_dest", model_q.branch_dest, result.branch_dest);
            end
        end

        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  rv32i_pkg::alu_op_e alu_op,
    input  rv32i_pkg::word_t   op_a,
    input  rv32i_pkg::word_t   op_b,
    output rv32i_pkg::word_t   alu_out
);

    import rv32i_pkg::*;

    logic [shamt_w-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;
    logic               equal;

    assign shamt       = op_b[shamt_w-1:0];    // Upper bits ignored
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;
    assign equal       = op_a == op_b;

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////

    always_comb begin
        case (alu_op)
            alu_add: begin
                alu_out = op_a + op_b;
            end
            alu_sub: begin
                alu_out = op_a - op_b;
            end
            alu_sll: begin
                alu_out = op_a << shamt;
            end
            alu_slt: begin
                alu_out = {{(xlen-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                alu_out = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            alu_xor: begin
                alu_out = op_a ^ op_b;
            end
            alu_srl: begin
                alu_out = op_a >> shamt;
            end
            alu_sra: begin
                alu_out = word_t'($signed(op_a) >>> shamt);    // Keeps the sign
            end
            alu_or: begin
                alu_out = op_a | op_b;
            end
            alu_and: begin
                alu_out = op_a & op_b;
            end
            alu_eq: begin
                alu_out = {{(xlen-1){1'b0}}, equal};
            end
            default: begin
                alu_out = '0;    // Spare codes
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/ex_branch_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ex_branch_gen (
    input  rv32i_pkg::br_op_e br_op,
    input  rv32i_pkg::word_t  pc,
    input  rv32i_pkg::word_t  rs1,
    input  rv32i_pkg::word_t  imm,
    output rv32i_pkg::word_t  branch_dest
);

    import rv32i_pkg::*;

    word_t base;

    // Base address for the target adder
    // br_none still produces PC plus imm, pc_sel keeps it unused
    always_comb begin
        case (br_op)
            br_reg_rel: begin
                base = rs1;    // Forwarded value
            end
            br_pc_rel: begin
                base = pc;
            end
            default: begin
                base = pc;
            end
        endcase
    end

    // One shared adder for both kinds
    assign branch_dest = base + imm;

endmodule

`default_nettype wire

// File: source/ex_control.sv
`timescale 1ns/1ps
`default_nettype none

module ex_control (
    input  logic                    Clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  rv32i_pkg::ex_ctrl_t     ctrl,
    input  rv32i_pkg::ex_operands_t ops,
    input  rv32i_pkg::word_t        rs1_fwd,
    input  rv32i_pkg::word_t        rs2_fwd,
    input  rv32i_pkg::word_t        alu_out,
    input  rv32i_pkg::word_t        branch_dest,
    output rv32i_pkg::alu_op_e      alu_op,
    output rv32i_pkg::word_t        op_a,
    output rv32i_pkg::word_t        op_b,
    output rv32i_pkg::ex_result_t   result
);

    import rv32i_pkg::*;

    logic  is_branch;
    logic  take;             // Redirect the PC
    logic  valid_q;
    logic  pc_sel_q;
    word_t alu_result_q;
    word_t branch_dest_q;

    //////////////////////////////////////////////////
    // ALU operands
    //////////////////////////////////////////////////

    always_comb begin
        if (ctrl.jump) begin
            // Link address
            op_a   = ops.imm1;
            op_b   = link_incr;
            alu_op = alu_add;
        end else begin
            alu_op = ctrl.alu_op;
            case (ctrl.src_sel)
                src_ri: begin
                    op_a = rs1_fwd;
                    op_b = ops.imm2;
                end
                src_ir: begin
                    op_a = ops.imm1;
                    op_b = rs2_fwd;
                end
                src_ii: begin
                    op_a = ops.imm1;
                    op_b = ops.imm2;
                end
                default: begin
                    op_a = rs1_fwd;    // src_rr
                    op_b = rs2_fwd;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Branch decision
    //////////////////////////////////////////////////

    assign is_branch = (ctrl.br_op != br_none);

    // Compares return zero or one, bit zero is enough
    always_comb begin
        if (ctrl.jump) begin
            take = 1'b1;
        end else if (is_branch) begin
            take = alu_out[0] ^ ctrl.br_invert;
        end else begin
            take = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            valid_q  <= 1'b0;
            pc_sel_q <= 1'b0;
        end else begin
            valid_q  <= in_valid;
            pc_sel_q <= in_valid & take;    // No redirect from a bubble
        end
    end

    // Payload holds across bubbles
    always_ff @(posedge Clk) begin
        if (in_valid) begin
            alu_result_q  <= alu_out;
            branch_dest_q <= branch_dest;
        end
    end

    assign result = '{
        valid:       valid_q,
        alu_result:  alu_result_q,
        branch_dest: branch_dest_q,
        pc_sel:      pc_sel_q
    };

    // A redirect only travels with a live instruction
    a_pc_sel_valid: assert property (@(posedge Clk) disable iff (rst)
        result.pc_sel |-> result.valid)
        else $error("pc_sel set on an invalid result");

    // Plain jump always redirects one cycle later
    a_jump_taken: assert property (@(posedge Clk) disable iff (rst)
        (in_valid && ctrl.jump && ctrl.br_op == br_none) |=> result.pc_sel)
        else $error("jump left pc_sel low");

endmodule

`default_nettype wire

// File: source/ex_forward_mux.sv
`timescale 1ns/1ps
`default_nettype none

module ex_forward_mux (
    input  rv32i_pkg::ex_operands_t ops,
    input  rv32i_pkg::fwd_sel_e     fwd_a,
    input  rv32i_pkg::fwd_sel_e     fwd_b,
    input  rv32i_pkg::word_t        mem_result,
    input  rv32i_pkg::word_t        wb_result,
    output rv32i_pkg::word_t        rs1_fwd,
    output rv32i_pkg::word_t        rs2_fwd
);

    import rv32i_pkg::*;

    // Memory stage is the youngest producer, so the hazard unit
    // sends fwd_mem ahead of fwd_wb when both match
    function automatic word_t pick_src(
        input fwd_sel_e sel,
        input word_t    reg_val,
        input word_t    mem_val,
        input word_t    wb_val
    );
        word_t val;
        case (sel)
            fwd_mem: val = mem_val;
            fwd_wb:  val = wb_val;
            default: val = reg_val;    // Register file copy
        endcase
        return val;
    endfunction

    assign rs1_fwd = pick_src(fwd_a, ops.rs1, mem_result, wb_result);
    assign rs2_fwd = pick_src(fwd_b, ops.rs2, mem_result, wb_result);

    //////////////////////////////////////////////////
    // Select checks
    //////////////////////////////////////////////////

    // Code 2'b11 has no source behind it
    always_comb begin
        a_fwd_a_known: assert (fwd_a inside {fwd_reg, fwd_mem, fwd_wb})
            else $error("fwd_a select %0d has no source", fwd_a);
        a_fwd_b_known: assert (fwd_b inside {fwd_reg, fwd_mem, fwd_wb})
            else $error("fwd_b select %0d has no source", fwd_b);
    end

endmodule

`default_nettype wire

// File: source/rv32i_ex.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_ex (
    input  logic                    Clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  rv32i_pkg::ex_ctrl_t     in_ctrl,
    input  rv32i_pkg::ex_operands_t in_ops,
    input  rv32i_pkg::fwd_sel_e     fwd_a,
    input  rv32i_pkg::fwd_sel_e     fwd_b,
    input  rv32i_pkg::word_t        mem_result,
    input  rv32i_pkg::word_t        wb_result,
    output rv32i_pkg::ex_result_t   result
);

    import rv32i_pkg::*;

    word_t   rs1_fwd;
    word_t   rs2_fwd;
    word_t   op_a;
    word_t   op_b;
    word_t   alu_out;
    word_t   branch_dest;
    alu_op_e alu_op;

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    ex_forward_mux i_forward_mux (
        .ops        (in_ops),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .mem_result (mem_result),
        .wb_result  (wb_result),
        .rs1_fwd    (rs1_fwd),
        .rs2_fwd    (rs2_fwd)
    );

    ex_alu i_alu (
        .alu_op  (alu_op),
        .op_a    (op_a),
        .op_b    (op_b),
        .alu_out (alu_out)
    );

    // Target base uses the forwarded rs1 for JALR
    ex_branch_gen i_branch_gen (
        .br_op       (in_ctrl.br_op),
        .pc          (in_ops.pc),
        .rs1         (rs1_fwd),
        .imm         (in_ops.imm2),
        .branch_dest (branch_dest)
    );

    //////////////////////////////////////////////////
    // Control and pipeline register
    //////////////////////////////////////////////////

    ex_control i_control (
        .Clk         (Clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .ctrl        (in_ctrl),
        .ops         (in_ops),
        .rs1_fwd     (rs1_fwd),
        .rs2_fwd     (rs2_fwd),
        .alu_out     (alu_out),
        .branch_dest (branch_dest),
        .alu_op      (alu_op),
        .op_a        (op_a),
        .op_b        (op_b),
        .result      (result)
    );

endmodule

`default_nettype wire

// File: source/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    //////////////////////////////////////////////////
    // Widths and constants
    //////////////////////////////////////////////////

    localparam int xlen    = 32;
    localparam int shamt_w = 5;    // RV32I shifts use five bits

    typedef logic [xlen-1:0] word_t;

    // PCs count words, so the link address is PC plus one
    localparam word_t link_incr = word_t'(1);

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9,
        alu_eq   = 4'd10    // Equality for BEQ and BNE
    } alu_op_e;

    typedef enum logic [1:0] {
        src_rr = 2'b00,
        src_ri = 2'b01,
        src_ir = 2'b10,
        src_ii = 2'b11
    } src_sel_e;

    // Upper bit marks a control transfer
    typedef enum logic [1:0] {
        br_none    = 2'b00,
        br_pc_rel  = 2'b10,    // Conditional branches and JAL
        br_reg_rel = 2'b11     // JALR
    } br_op_e;

    typedef enum logic [1:0] {
        fwd_reg = 2'b00,
        fwd_mem = 2'b01,
        fwd_wb  = 2'b10
    } fwd_sel_e;

    //////////////////////////////////////////////////
    // Stage bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        alu_op_e  alu_op;
        src_sel_e src_sel;
        br_op_e   br_op;
        logic     br_invert;    // Taken on a zero compare
        logic     jump;
    } ex_ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t rs1;
        word_t rs2;
        word_t imm1;    // Holds the PC for jumps
        word_t imm2;
    } ex_operands_t;

    typedef struct packed {
        logic  valid;
        word_t alu_result;
        word_t branch_dest;
        logic  pc_sel;    // Load branch_dest into the PC
    } ex_result_t;

endpackage

`default_nettype wire
